// File: logic/cpu_pkg.sv
// Word widths, opcode and execute encodings, and the three views of an instruction word
`default_nettype none

package cpu_pkg;

    localparam int data_w      = 16;   // Register and data word
    localparam int reg_idx_w   = 4;    // Sixteen registers
    localparam int imm_w       = 5;    // Branch and load/store offset
    localparam int target_w    = 13;   // Absolute jump field
    localparam int data_addr_w = 8;

    typedef enum logic [2:0] {
        add_sub  = 3'd0,
        slt_mult = 3'd1,
        load     = 3'd2,
        store    = 3'd3,
        beq      = 3'd4,
        jump     = 3'd5
    } opcode_t;

    // Operation the execute unit registers into result
    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_slt,
        op_mult,
        op_addr
    } alu_op_t;

    typedef struct packed {
        opcode_t              opcode;
        logic [reg_idx_w-1:0] rs;
        logic [reg_idx_w-1:0] rt;
        logic [reg_idx_w-1:0] rd;
        logic                 func;   // Sub for add_sub, mult for slt_mult
    } r_view_t;

    typedef struct packed {
        opcode_t                  opcode;
        logic [reg_idx_w-1:0]     rs;
        logic [reg_idx_w-1:0]     rt;
        logic signed [imm_w-1:0]  imm;
    } i_view_t;

    typedef struct packed {
        opcode_t             opcode;
        logic [target_w-1:0] target;
    } j_view_t;

    typedef union packed {
        r_view_t r;
        i_view_t i;
        j_view_t j;
    } instr_t;

endpackage

`default_nettype wire

// File: logic/pc_unit.sv
// Program counter with step, relative branch and absolute jump updates
`timescale 1ns/10ps
`default_nettype none

module pc_unit import cpu_pkg::*; #(
    parameter int inst_addr_w = 8
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        pc_step,
    input  wire                        pc_branch,
    input  wire                        pc_jump,
    input  wire signed [imm_w-1:0]     imm,
    input  wire [target_w-1:0]         jump_target,
    output logic [inst_addr_w-1:0]     pc
);

    logic [inst_addr_w-1:0] pc_next_seq;
    logic [inst_addr_w-1:0] imm_ext;

    assign pc_next_seq = pc + inst_addr_w'(1);
    assign imm_ext     = {{(inst_addr_w - imm_w){imm[imm_w-1]}}, imm};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (pc_jump) begin
            pc <= jump_target[inst_addr_w-1:0];   // Upper target bits dropped
        end else if (pc_branch) begin
            pc <= pc_next_seq + imm_ext;          // Offset from next instruction
        end else if (pc_step) begin
            pc <= pc_next_seq;
        end
    end

endmodule

`default_nettype wire

// File: logic/reg_file.sv
// Sixteen signed registers with registered rs/rt reads and a single write port
`timescale 1ns/10ps
`default_nettype none

module reg_file import cpu_pkg::*; (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire [reg_idx_w-1:0]        rs_idx,
    input  wire [reg_idx_w-1:0]        rt_idx,
    input  wire [reg_idx_w-1:0]        rd_idx,   // Write index
    input  wire [data_w-1:0]           wr_data,
    input  wire                        rf_we,
    output logic signed [data_w-1:0]   rs_data,
    output logic signed [data_w-1:0]   rt_data
);

    localparam int num_regs = 2 ** reg_idx_w;

    logic signed [data_w-1:0] regs [num_regs];

    // ################################################
    // Write port
    // ################################################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_we) begin
            regs[rd_idx] <= wr_data;
        end
    end

    // ################################################
    // Read ports
    // ################################################

    // Indices come straight from the instruction register, so the
    // outputs track the current instruction one cycle after it loads
    always_ff @(posedge clk) begin
        rs_data <= regs[rs_idx];
        rt_data <= regs[rt_idx];
    end

endmodule

`default_nettype wire

// File: logic/exec_unit.sv
// Adder/subtractor, signed compare, two-stage multiplier and load/store address
`timescale 1ns/10ps
`default_nettype none

module exec_unit import cpu_pkg::*; (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire alu_op_t                  alu_op,
    input  wire                           mult_start,
    input  wire signed [data_w-1:0]       rs_data,
    input  wire signed [data_w-1:0]       rt_data,
    input  wire signed [imm_w-1:0]        imm,
    output logic signed [data_w-1:0]      result,
    output logic                          rs_eq_rt,
    output logic [data_addr_w-1:0]        mem_addr
);

    logic signed [data_w-1:0] imm_ext;
    logic [data_w-1:0]        pp_lo;     // rs times low byte of rt
    logic [7:0]               pp_hi;     // Only its low byte reaches bits 15:8
    logic                     pp_valid;
    logic [data_w-1:0]        product;

    assign imm_ext  = {{(data_w - imm_w){imm[imm_w-1]}}, imm};
    assign rs_eq_rt = (rs_data == rt_data);
    assign mem_addr = result[data_addr_w-1:0];

    // ################################################
    // Multiplier, low half of the signed product
    // ################################################

    // Two's complement low bits match the unsigned product
    always_ff @(posedge clk) begin
        if (mult_start) begin
            pp_lo <= rs_data * {8'b0, rt_data[7:0]};
            pp_hi <= rs_data[7:0] * rt_data[15:8];
        end
        if (pp_valid)
            product <= pp_lo + {pp_hi, 8'b0};   // Stage two
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            pp_valid <= 1'b0;
        else
            pp_valid <= mult_start;
    end

    // ################################################
    // Result register
    // ################################################

    always_ff @(posedge clk) begin
        case (alu_op)
            op_add:  result <= rs_data + rt_data;   // Wraps on overflow
            op_sub:  result <= rs_data - rt_data;
            op_slt:  result <= {{(data_w - 1){1'b0}}, rs_data < rt_data};
            op_mult: result <= product;
            default: result <= rs_data + imm_ext;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/cpu_control.sv
// Instruction register, sequencing FSM, decode and retirement strobes
`timescale 1ns/10ps
`default_nettype none

module cpu_control import cpu_pkg::*; (
    input  wire                clk,
    input  wire                rst_n,
    input  wire [data_w-1:0]   inst_rdata,
    input  wire [data_w-1:0]   data_rdata,
    input  wire                rs_eq_rt,
    output instr_t             instr,
    output alu_op_t            alu_op,
    output logic               mult_start,
    output logic               rf_we,
    output logic               wb_sel,
    output logic               pc_step,
    output logic               pc_branch,
    output logic               pc_jump,
    output logic               data_we,
    output logic               io_stall,
    output logic [data_w-1:0]  load_data
);

    localparam logic [2:0] st_fetch      = 3'd0;   // inst_addr presented
    localparam logic [2:0] st_fetch_wait = 3'd1;   // Word returns, latched
    localparam logic [2:0] st_read_regs  = 3'd2;
    localparam logic [2:0] st_execute    = 3'd3;
    localparam logic [2:0] st_mult_wait  = 3'd4;   // Two cycles
    localparam logic [2:0] st_mem_access = 3'd5;   // data_addr presented
    localparam logic [2:0] st_mem_wait   = 3'd6;
    localparam logic [2:0] st_write_back = 3'd7;   // Retirement cycle

    logic [2:0] state;
    logic       mult_phase;
    opcode_t    opcode;
    logic       is_mult;
    logic       is_mem;
    logic       writes_reg;
    logic       retire;

    // ################################################
    // Decode
    // ################################################

    assign opcode     = instr.r.opcode;
    assign is_mult    = (opcode == slt_mult) && instr.r.func;
    assign is_mem     = (opcode == load) || (opcode == store);
    assign writes_reg = (opcode == add_sub) || (opcode == slt_mult) || (opcode == load);
    assign retire     = (state == st_write_back);

    always_comb begin
        case (opcode)
            add_sub:  alu_op = instr.r.func ? op_sub : op_add;
            slt_mult: alu_op = instr.r.func ? op_mult : op_slt;
            default:  alu_op = op_addr;   // Memory address; branch and jump ignore result
        endcase
    end

    // ################################################
    // Sequencing
    // ################################################

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= st_fetch;
            mult_phase <= 1'b0;
            instr      <= '0;
        end else begin
            case (state)
                st_fetch:      state <= st_fetch_wait;
                st_fetch_wait: begin
                    instr <= inst_rdata;
                    state <= st_read_regs;
                end
                st_read_regs:  state <= st_execute;
                st_execute: begin
                    if (is_mult)
                        state <= st_mult_wait;
                    else if (is_mem)
                        state <= st_mem_access;
                    else
                        state <= st_write_back;
                end
                st_mult_wait: begin
                    mult_phase <= !mult_phase;   // Back to 0 on exit
                    if (mult_phase)
                        state <= st_write_back;
                end
                st_mem_access: state <= st_mem_wait;
                st_mem_wait:   state <= st_write_back;
                default:       state <= st_fetch;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_mem_wait)
            load_data <= data_rdata;   // Word for the address sent last cycle
    end

    // Strobes, all single cycle
    assign mult_start = (state == st_execute) && is_mult;
    assign rf_we      = retire && writes_reg;
    assign wb_sel     = (opcode == load);
    assign data_we    = retire && (opcode == store);
    assign io_stall   = !retire;

    // Branch decision lives here; pc_unit only forms targets
    assign pc_branch  = retire && (opcode == beq) && rs_eq_rt;
    assign pc_jump    = retire && (opcode == jump);
    assign pc_step    = retire && !pc_branch && !pc_jump;

endmodule

`default_nettype wire

// File: logic/cpu_top.sv
// Processor top level connecting control, register file, execute unit and program counter
`timescale 1ns/10ps
`default_nettype none

module cpu_top import cpu_pkg::*; #(
    parameter int inst_addr_w = 8
) (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire [data_w-1:0]        inst_rdata,
    input  wire [data_w-1:0]        data_rdata,
    output logic [inst_addr_w-1:0]  inst_addr,
    output logic [data_addr_w-1:0]  data_addr,
    output logic [data_w-1:0]       data_wdata,
    output logic                    data_we,
    output logic                    io_stall
);

    instr_t                    instr;
    alu_op_t                   alu_op;
    logic                      mult_start;
    logic                      rf_we;
    logic                      wb_sel;    // High picks load_data
    logic                      pc_step;
    logic                      pc_branch;
    logic                      pc_jump;
    logic [data_w-1:0]         load_data;
    logic signed [data_w-1:0]  rs_data;
    logic signed [data_w-1:0]  rt_data;
    logic signed [data_w-1:0]  result;
    logic                      rs_eq_rt;
    logic [data_w-1:0]         wr_data;
    logic [reg_idx_w-1:0]      wr_idx;

    // Loads write rt, every other writer uses rd
    assign wr_data    = wb_sel ? load_data : result;
    assign wr_idx     = wb_sel ? instr.i.rt : instr.r.rd;
    assign data_wdata = rt_data;   // Store source register

    cpu_control u_cpu_control (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_rdata (inst_rdata),
        .data_rdata (data_rdata),
        .rs_eq_rt   (rs_eq_rt),
        .instr      (instr),
        .alu_op     (alu_op),
        .mult_start (mult_start),
        .rf_we      (rf_we),
        .wb_sel     (wb_sel),
        .pc_step    (pc_step),
        .pc_branch  (pc_branch),
        .pc_jump    (pc_jump),
        .data_we    (data_we),
        .io_stall   (io_stall),
        .load_data  (load_data)
    );

    reg_file u_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_idx  (instr.r.rs),
        .rt_idx  (instr.r.rt),
        .rd_idx  (wr_idx),
        .wr_data (wr_data),
        .rf_we   (rf_we),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    exec_unit u_exec_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .alu_op     (alu_op),
        .mult_start (mult_start),
        .rs_data    (rs_data),
        .rt_data    (rt_data),
        .imm        (instr.i.imm),
        .result     (result),
        .rs_eq_rt   (rs_eq_rt),
        .mem_addr   (data_addr)
    );

    pc_unit #(
        .inst_addr_w (inst_addr_w)
    ) u_pc_unit (
        .clk         (clk),
        .rst_n       (rst_n),
        .pc_step     (pc_step),
        .pc_branch   (pc_branch),
        .pc_jump     (pc_jump),
        .imm         (instr.i.imm),
        .jump_target (instr.j.target),
        .pc          (inst_addr)
    );

endmodule

`default_nettype wire

// File: tb/tb_clock.sv
// Free-running testbench clock and active-low reset that restarts on request
`timescale 1ns/10ps
`default_nettype none

module tb_clock (
    input  wire  reset_req,
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;   // 10 ns period
    end

    // Two cycles low, released on a falling edge
    always begin
        rst_n = 1'b0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;
        @(posedge reset_req);
    end

endmodule

`default_nettype wire

// File: tb/cpu_chk.sv
// Concurrent checks on the store strobe and retirement pulse, bound into cpu_control
`timescale 1ns/10ps
`default_nettype none

module cpu_chk (
    input wire clk,
    input wire rst_n,
    input wire data_we,
    input wire io_stall
);

    we_pulse: assert property (@(posedge clk) disable iff (!rst_n) data_we |=> !data_we)
        else $error("data_we stayed high for more than one cycle");

    retire_pulse: assert property (@(posedge clk) disable iff (!rst_n) !io_stall |=> io_stall)
        else $error("io_stall stayed low for more than one cycle");

    // A store only completes in the retirement cycle
    we_in_retire: assert property (@(posedge clk) disable iff (!rst_n) data_we |-> !io_stall)
        else $error("data_we was high while io_stall was high");

endmodule

bind cpu_control cpu_chk u_cpu_chk (
    .clk      (clk),
    .rst_n    (rst_n),
    .data_we  (data_we),
    .io_stall (io_stall)
);

`default_nettype wire

// File: tb/cpu_tb.sv
// Testbench with memory models, instruction-set reference model, test programs and checks
`timescale 1ns/10ps
`default_nettype none

module cpu_tb import cpu_pkg::*; ();

    localparam int mem_words      = 256;
    localparam int retire_timeout = 20;   // Longest instruction is 7 cycles

    logic              clk;
    logic              rst_n;
    logic              reset_req  = 1'b0;
    logic [15:0]       inst_rdata = '0;
    logic [15:0]       data_rdata = '0;
    logic [7:0]        inst_addr;
    logic [7:0]        data_addr;
    logic [15:0]       data_wdata;
    logic              data_we;
    logic              io_stall;

    logic [15:0]        imem [mem_words];
    logic [15:0]        dmem [mem_words];
    logic [15:0]        m_dmem [mem_words];   // Reference copy
    logic signed [15:0] m_regs [16];
    logic [7:0]         m_pc;
    logic [7:0]         m_st_addr;
    logic [15:0]        m_st_data;
    logic [7:0]         inst_addr_q;
    logic [7:0]         data_addr_q;
    logic [15:0]        lfsr = 16'd20;

    logic checking         = 1'b0;
    logic halted           = 1'b0;
    logic pc_check_pending = 1'b0;
    int   checked          = 0;
    int   errors           = 0;
    int   tests_run        = 0;
    int   tests_failed     = 0;
    int   prog_len         = 0;

    tb_clock u_tb_clock (
        .reset_req (reset_req),
        .clk       (clk),
        .rst_n     (rst_n)
    );

    cpu_top #(
        .inst_addr_w (8)
    ) u_cpu_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_rdata (inst_rdata),
        .data_rdata (data_rdata),
        .inst_addr  (inst_addr),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_we    (data_we),
        .io_stall   (io_stall)
    );

    // ##################################################
    // Memory models
    // ##################################################

    always @(posedge clk) begin
        inst_addr_q <= inst_addr;
        data_addr_q <= data_addr;
        if (data_we)
            dmem[data_addr] <= data_wdata;
    end

    always @(negedge clk) begin
        inst_rdata <= imem[inst_addr_q];   // Word for last edge's address
        data_rdata <= dmem[data_addr_q];
    end

    // ##################################################
    // Encoders, random source and reference model
    // ##################################################

    function automatic logic [15:0] r_word(opcode_t op, int rs, int rt, int rd, logic f);
        return {op, 4'(rs), 4'(rt), 4'(rd), f};
    endfunction

    function automatic logic [15:0] i_word(opcode_t op, int rs, int rt, int imm);
        return {op, 4'(rs), 4'(rt), 5'(imm)};
    endfunction

    function automatic logic [15:0] j_word(int target);
        return {jump, 13'(target)};
    endfunction

    // Galois LFSR, one step per bit
    function automatic int rand_bits(int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hb400) : (lfsr >> 1);
            v = (v << 1) | lfsr[0];
        end
        return v;
    endfunction

    // Executes the word at m_pc on the shadow state, returns 1 for a store
    function automatic logic ref_execute();
        logic [15:0]        w;
        logic signed [15:0] a;
        logic signed [15:0] b;
        logic [7:0]         addr;
        logic [7:0]         next_pc;
        logic               is_store;
        w        = imem[m_pc];
        a        = m_regs[w[12:9]];
        b        = m_regs[w[8:5]];
        addr     = 8'(a + {{11{w[4]}}, w[4:0]});
        next_pc  = m_pc + 8'd1;
        is_store = 1'b0;
        case (w[15:13])
            add_sub:  m_regs[w[4:1]] = w[0] ? a - b : a + b;
            slt_mult: m_regs[w[4:1]] = w[0] ? 16'(a * b) : {15'b0, a < b};
            load:     m_regs[w[8:5]] = m_dmem[addr];
            store: begin
                m_dmem[addr] = b;
                m_st_addr    = addr;
                m_st_data    = b;
                is_store     = 1'b1;
            end
            beq:      if (a == b) next_pc = next_pc + {{3{w[4]}}, w[4:0]};
            jump:     next_pc = w[7:0];
            default:  ;
        endcase
        m_pc = next_pc;
        return is_store;
    endfunction

    // ##################################################
    // Comparison at each retirement
    // ##################################################

    always @(negedge clk) begin
        logic exp_store;
        if (rst_n && checking) begin
            if (pc_check_pending) begin
                assert (inst_addr == m_pc)
                else begin
                    $display("mismatch at %0t: inst_addr %0d, model pc %0d",
                             $time, inst_addr, m_pc);
                    errors++;
                end
                pc_check_pending = 1'b0;
                halted = (imem[m_pc] == {jump, 5'b0, m_pc});   // Jump to itself
                checked++;
            end
            if (!io_stall) begin
                exp_store = ref_execute();
                assert (data_we == exp_store)
                else begin
                    $display("mismatch at %0t: data_we %b, model %b", $time, data_we, exp_store);
                    errors++;
                end
                if (exp_store) begin
                    assert (data_addr == m_st_addr && data_wdata == m_st_data)
                    else begin
                        $display("mismatch at %0t: store %h to %0d, model %h to %0d", $time,
                                 data_wdata, data_addr, m_st_data, m_st_addr);
                        errors++;
                    end
                end
                pc_check_pending = 1'b1;
            end else begin
                assert (!data_we)
                else begin
                    $display("mismatch at %0t: data_we high outside retirement", $time);
                    errors++;
                end
            end
        end
    end

    // ##################################################
    // Test sequencing
    // ##################################################

    task automatic put(logic [15:0] word);
        imem[prog_len] = word;
        prog_len++;
    endtask

    task automatic preset(int addr, logic [15:0] value);
        dmem[addr]   = value;
        m_dmem[addr] = value;
    endtask

    // Resets the DUT and clears memories and model while reset is low
    task automatic start_test();
        int cycles;
        @(negedge clk);
        reset_req = 1'b1;
        cycles = 0;
        while (rst_n && cycles < 4) begin
            @(posedge clk);
            cycles++;
        end
        reset_req = 1'b0;
        if (rst_n) begin
            $display("reset was never asserted at %0t", $time);
            errors++;
        end
        for (int a = 0; a < mem_words; a++) begin
            imem[a]   = j_word(a);
            dmem[a]   = {8'(a) ^ 8'h5a, ~8'(a)};
            m_dmem[a] = dmem[a];
        end
        for (int r = 0; r < 16; r++) begin
            m_regs[r] = '0;
        end
        m_pc             = '0;
        halted           = 1'b0;
        pc_check_pending = 1'b0;
        prog_len         = 0;
    endtask

    task automatic run_program(string name);
        int   start_errors;
        int   last;
        int   cycles;
        logic timed_out;
        start_errors = errors;
        timed_out    = 1'b0;
        cycles       = 0;
        while (!rst_n && cycles < 8) begin
            @(posedge clk);
            cycles++;
        end
        checking = 1'b1;
        while (!halted && !timed_out) begin
            last   = checked;
            cycles = 0;
            while (checked == last && cycles < retire_timeout) begin
                @(posedge clk);
                cycles++;
            end
            if (checked == last) begin
                $display("processor never retired within %0d cycles at %0t",
                         retire_timeout, $time);
                errors++;
                timed_out = 1'b1;
            end
        end
        checking = 1'b0;
        for (int a = 0; a < mem_words; a++) begin
            assert (dmem[a] == m_dmem[a])
            else begin
                $display("mismatch at %0t: %s data word %0d is %h, model %h",
                         $time, name, a, dmem[a], m_dmem[a]);
                errors++;
            end
        end
        tests_run++;
        if (errors != start_errors)
            tests_failed++;
        $display("test %0d %s %s", tests_run, name,
                 (errors == start_errors) ? "passed" : "failed");
    endtask

    initial begin
        // Add, sub and slt with overflow wrap and negative compares
        start_test();
        preset(0, 16'h7fff);
        preset(1, 16'h0001);
        preset(2, 16'h8000);
        preset(3, 16'hfffe);
        for (int k = 0; k < 4; k++) begin
            put(i_word(load, 0, k + 1, k));
        end
        put(r_word(add_sub, 1, 2, 5, 1'b0));
        put(r_word(add_sub, 3, 2, 6, 1'b1));
        put(r_word(slt_mult, 3, 4, 7, 1'b0));
        put(r_word(slt_mult, 4, 3, 8, 1'b0));
        put(r_word(slt_mult, 4, 2, 9, 1'b0));
        put(r_word(add_sub, 3, 3, 10, 1'b0));
        for (int k = 5; k <= 10; k++) begin
            put(i_word(store, 0, k, k + 3));
        end
        run_program("alu");

        // Signed multiply, low half kept
        start_test();
        preset(0, 16'hfffd);
        preset(1, 16'hfff9);
        preset(2, 16'h0123);
        preset(3, 16'h7fff);
        preset(4, 16'h8000);
        for (int k = 0; k < 5; k++) begin
            put(i_word(load, 0, k + 1, k));
        end
        put(r_word(slt_mult, 1, 2, 6, 1'b1));
        put(r_word(slt_mult, 3, 4, 7, 1'b1));
        put(r_word(slt_mult, 1, 3, 8, 1'b1));
        put(r_word(slt_mult, 4, 4, 9, 1'b1));
        put(r_word(slt_mult, 5, 2, 10, 1'b1));
        for (int k = 6; k <= 10; k++) begin
            put(i_word(store, 0, k, k + 2));
        end
        run_program("mult");

        // Loads, arithmetic, stores at negative offsets from a base
        start_test();
        preset(4, 16'd40);
        preset(5, 16'h1234);
        preset(6, 16'hf00d);
        put(i_word(load, 0, 1, 4));
        put(i_word(load, 0, 2, 5));
        put(i_word(load, 0, 3, 6));
        put(r_word(add_sub, 2, 3, 4, 1'b0));
        put(i_word(store, 1, 4, -3));
        put(r_word(add_sub, 2, 3, 5, 1'b1));
        put(i_word(store, 1, 5, -16));
        put(i_word(load, 1, 6, -3));
        put(r_word(add_sub, 6, 2, 7, 1'b0));
        put(i_word(store, 1, 7, -1));
        put(i_word(store, 1, 3, 15));
        run_program("load_store");

        // Taken and untaken branches, a backward loop and a jump
        start_test();
        preset(0, 16'd7);
        preset(1, 16'd7);
        preset(2, 16'd21);
        put(i_word(load, 0, 1, 0));
        put(i_word(load, 0, 2, 1));
        put(i_word(load, 0, 5, 2));
        put(i_word(beq, 1, 2, 2));       // Taken, skips two stores
        put(i_word(store, 0, 1, 10));
        put(i_word(store, 0, 1, 11));
        put(i_word(beq, 1, 0, 3));       // Not taken
        put(r_word(add_sub, 3, 1, 3, 1'b0));
        put(i_word(store, 0, 3, 12));
        put(i_word(beq, 3, 5, 1));
        put(i_word(beq, 0, 0, -4));      // Back to the add
        put(j_word(13'h10d));            // Upper bits dropped, lands on 13
        put(i_word(store, 0, 3, 13));
        put(i_word(store, 0, 1, 14));
        run_program("branch");

        // Random mix after loading r1 to r15
        start_test();
        for (int k = 1; k < 16; k++) begin
            put(i_word(load, 0, k, k));
        end
        for (int n = 0; n < 40; n++) begin
            int kind;
            int rs;
            int rt;
            int rd;
            int imm;
            kind = rand_bits(3);
            rs   = rand_bits(4);
            rt   = rand_bits(4);
            rd   = rand_bits(4);
            imm  = rand_bits(5);
            case (kind)
                0, 1:    put(r_word(add_sub, rs, rt, rd, 1'b0));
                2:       put(r_word(add_sub, rs, rt, rd, 1'b1));
                3:       put(r_word(slt_mult, rs, rt, rd, 1'b0));
                4, 5:    put(r_word(slt_mult, rs, rt, rd, 1'b1));
                default: put(i_word(store, rs, rt, imm));
            endcase
        end
        run_program("random");

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
logic/cpu_pkg.sv
logic/pc_unit.sv
logic/reg_file.sv
logic/exec_unit.sv
logic/cpu_control.sv
logic/cpu_top.sv
tb/tb_clock.sv
tb/cpu_chk.sv
tb/cpu_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f vlog.f -o cpu_sim \
    && ./obj_dir/cpu_sim > sim.log 2>&1 \
    || echo "build or simulation returned an error"
[ -f sim.log ] && cat sim.log
grep -qx "PASS: all tests" sim.log && echo "result: passed" || { echo "result: failed"; exit 1; }
